//--- hdl/core_config.svh
// build-time constants for the clk_74a glue
// bridge widths, reset hold, hsync delay
// data-slot ids, save size and video slot word bits

`ifndef CORE_CONFIG_SVH
`define CORE_CONFIG_SVH

// bridge address and data width
`define CORE_ADDR_W 32

// reset hold after a reg_reset write, in clk_74a cycles
`define CORE_RESET_HOLD 1048576

// hsync delay load, keeps hs clear of the vs pulse
`define CORE_HS_DELAY 7

// data-slot ids as given in data.json
`define CORE_SLOT_ROM_ID 16'd0
`define CORE_SLOT_PALETTE_ID 16'd11

// save size word and where it lands in the datatable
// slot index 1 -> word 1 * 2 + 1
`define CORE_SAVE_SIZE 32'h0004_0000
`define CORE_SAVE_TABLE_ADDR 10'd3

// settings field widths
`define CORE_PALETTE_W 3
`define CORE_AIM_SPEED_W 8
`define CORE_TURBO_W 3

// video
`define CORE_RGB_W 24
`define CORE_SLOT_HIDE_BIT 14
`define CORE_SLOT_SQUARE_BIT 13

`endif

//--- hdl/core_pkg.sv
// shared types for the clk_74a glue
// bridge register offsets, region codes, download state

`include "core_config.svh"

package core_pkg;

  ////////////////////////////////////////
  // bridge register map
  ////////////////////////////////////////

  // write-only settings, one field per word
  typedef enum logic [`CORE_ADDR_W-1:0] {
    // core control
    reg_reset         = 32'h0000_0050,
    reg_region        = 32'h0000_0054,
    // video settings
    reg_hide_overscan = 32'h0000_0200,
    reg_mask_edges    = 32'h0000_0204,
    reg_extra_sprites = 32'h0000_0208,
    reg_palette       = 32'h0000_020C,
    reg_square_pixels = 32'h0000_0210,
    // input settings
    reg_multitap      = 32'h0000_0300,
    reg_lightgun      = 32'h0000_0304,
    reg_aim_speed     = 32'h0000_0308,
    reg_swap          = 32'h0000_030C,
    reg_turbo         = 32'h0000_0310
  } bridge_reg_e;

  // console region, drives the core sys_type
  typedef enum logic [1:0] {
    region_ntsc  = 2'd0,
    region_pal   = 2'd1,
    region_dendy = 2'd2
  } region_e;

  // data-slot download tracker
  typedef enum logic {
    dl_idle,
    dl_active
  } download_e;

endpackage

//--- hdl/settings_regs.sv
// bridge-written emulator settings
// reset-hold down-counter and region-change reset
// effective overscan hide for the video slot word

`timescale 1ns/1ps

`include "core_config.svh"

module settings_regs
  import core_pkg::*;
#(
  parameter int unsigned RESET_HOLD = `CORE_RESET_HOLD
) (
  input  logic                         clk_74a,
  input  logic                         pll_core_locked,

  // bridge write strobe
  input  logic                         bridge_wr,
  input  logic [`CORE_ADDR_W-1:0]      bridge_addr,
  input  logic [`CORE_ADDR_W-1:0]      bridge_wr_data,

  // settings toward the core
  output region_e                      region,
  output logic                         hide_overscan_eff,
  output logic [1:0]                   mask_vid_edges,
  output logic                         allow_extra_sprites,
  output logic [`CORE_PALETTE_W-1:0]   selected_palette,
  output logic                         square_pixels,
  output logic                         multitap_enabled,
  output logic                         lightgun_enabled,
  output logic [`CORE_AIM_SPEED_W-1:0] lightgun_dpad_aim_speed,
  output logic                         swap_controllers,
  output logic [`CORE_TURBO_W-1:0]     turbo_speed,
  output logic                         external_reset
);

  // counter wide enough to hold RESET_HOLD itself
  localparam int CNT_W = $clog2(RESET_HOLD + 1);

  logic             hide_overscan;
  region_e          prev_region;
  logic [CNT_W-1:0] reset_cnt;

  ////////////////////////////////////////
  // register file and reset hold
  ////////////////////////////////////////

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      region                  <= region_ntsc;
      prev_region             <= region_ntsc;
      hide_overscan           <= 1'b0;
      mask_vid_edges          <= '0;
      allow_extra_sprites     <= 1'b0;
      selected_palette        <= '0;
      square_pixels           <= 1'b0;
      multitap_enabled        <= 1'b0;
      lightgun_enabled        <= 1'b0;
      lightgun_dpad_aim_speed <= '0;
      swap_controllers        <= 1'b0;
      turbo_speed             <= '0;
      reset_cnt               <= '0;
    end else begin
      // one cycle behind, for change detect
      prev_region <= region;

      // hold counts down to zero and sticks
      if (reset_cnt != '0) begin
        reset_cnt <= reset_cnt - 1'b1;
      end

      if (bridge_wr) begin
        // low bits only, at field width
        case (bridge_addr)
          reg_reset:         reset_cnt <= CNT_W'(RESET_HOLD);
          reg_region:        region <= region_e'(bridge_wr_data[1:0]);
          reg_hide_overscan: hide_overscan <= bridge_wr_data[0];
          reg_mask_edges:    mask_vid_edges <= bridge_wr_data[1:0];
          reg_extra_sprites: allow_extra_sprites <= bridge_wr_data[0];
          reg_palette: begin
            selected_palette <= bridge_wr_data[`CORE_PALETTE_W-1:0];
          end
          reg_square_pixels: square_pixels <= bridge_wr_data[0];
          reg_multitap:      multitap_enabled <= bridge_wr_data[0];
          reg_lightgun:      lightgun_enabled <= bridge_wr_data[0];
          reg_aim_speed: begin
            lightgun_dpad_aim_speed <= bridge_wr_data[`CORE_AIM_SPEED_W-1:0];
          end
          reg_swap:          swap_controllers <= bridge_wr_data[0];
          reg_turbo:         turbo_speed <= bridge_wr_data[`CORE_TURBO_W-1:0];
          // unmapped offset, nothing moves
          default: ;
        endcase
      end
    end
  end

  ////////////////////////////////////////
  // derived outputs
  ////////////////////////////////////////

  // held reset, or one cycle right after a region change
  assign external_reset = (reset_cnt != '0) || (region != prev_region);

  // overscan hide only means something on ntsc timing
  assign hide_overscan_eff = hide_overscan && (region == region_ntsc);

  // hold count bounded by the load value
  a_reset_cnt_bound : assert property (
    @(posedge clk_74a) disable iff (!pll_core_locked)
    reset_cnt <= RESET_HOLD
  );

endmodule

//--- hdl/dataslot_tracker.sv
// data-slot download tracking with latched slot id
// per-slot download flags for program image and palette
// save-size datatable write

`timescale 1ns/1ps

`include "core_config.svh"

module dataslot_tracker
  import core_pkg::*;
(
  input  logic        clk_74a,
  input  logic        pll_core_locked,

  // data-slot strobes from the host command handler
  input  logic        dataslot_requestwrite,
  input  logic [15:0] dataslot_requestwrite_id,
  input  logic        dataslot_allcomplete,

  // from the core, mapper has battery ram
  input  logic        has_save,

  output logic        is_downloading,
  output logic        ioctl_download,
  output logic        palette_download,

  // datatable port
  output logic [9:0]  datatable_addr,
  output logic        datatable_wren,
  output logic [31:0] datatable_data
);

  download_e   state;
  logic [15:0] slot_id;

  // request wins over a same-cycle allcomplete
  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      state   <= dl_idle;
      slot_id <= '0;
    end else if (dataslot_requestwrite) begin
      state   <= dl_active;
      // latched, stays put for the whole transfer
      slot_id <= dataslot_requestwrite_id;
    end else if (dataslot_allcomplete) begin
      state <= dl_idle;
    end
  end

  assign is_downloading   = (state == dl_active);
  assign ioctl_download   = is_downloading && (slot_id == `CORE_SLOT_ROM_ID);
  assign palette_download = is_downloading && (slot_id == `CORE_SLOT_PALETTE_ID);

  ////////////////////////////////////////
  // save size datatable entry
  ////////////////////////////////////////

  // fixed word, rewritten every cycle once out of reset
  assign datatable_addr = `CORE_SAVE_TABLE_ADDR;

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      datatable_wren <= 1'b0;
      datatable_data <= '0;
    end else begin
      datatable_wren <= 1'b1;
      datatable_data <= has_save ? `CORE_SAVE_SIZE : 32'h0;
    end
  end

  // slot ids are distinct, so only one loader ever runs
  a_one_loader : assert property (
    @(posedge clk_74a) disable iff (!pll_core_locked)
    !(ioctl_download && palette_download)
  );

endmodule

//--- hdl/video_conditioner.sv
// registered video stream toward the scaler
// data enable and pixels, end-of-line slot word
// delayed hsync pulse and single-cycle vsync pulse

`timescale 1ns/1ps

`include "core_config.svh"

module video_conditioner (
  input  logic                   clk_74a,
  input  logic                   pll_core_locked,

  // raw timing and pixels from the core
  input  logic                   core_hblank,
  input  logic                   core_vblank,
  input  logic                   core_hs,
  input  logic                   core_vs,
  input  logic [`CORE_RGB_W-1:0] core_rgb,

  // flags carried in the slot word
  input  logic                   hide_overscan_eff,
  input  logic                   square_pixels,

  output logic                   video_de,
  output logic                   video_hs,
  output logic                   video_vs,
  output logic [`CORE_RGB_W-1:0] video_rgb
);

  localparam int HS_W = $clog2(`CORE_HS_DELAY + 1);

  logic                   de;
  logic                   de_prev;
  logic                   hs_prev;
  logic                   vs_prev;
  logic [HS_W-1:0]        hs_delay;
  logic [`CORE_RGB_W-1:0] slot_word;

  // active area, neither blank
  assign de = !(core_hblank || core_vblank);

  // scaler slot word, sent once after each active line
  always_comb begin
    slot_word                        = '0;
    slot_word[`CORE_SLOT_HIDE_BIT]   = hide_overscan_eff;
    slot_word[`CORE_SLOT_SQUARE_BIT] = square_pixels;
  end

  ////////////////////////////////////////
  // output registers
  ////////////////////////////////////////

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      video_de  <= 1'b0;
      video_hs  <= 1'b0;
      video_vs  <= 1'b0;
      video_rgb <= '0;
      de_prev   <= 1'b0;
      hs_prev   <= 1'b0;
      vs_prev   <= 1'b0;
      hs_delay  <= '0;
    end else begin
      video_de <= de;

      // pixels while active
      // slot word on the first blank cycle
      // black elsewhere
      if (de) begin
        video_rgb <= core_rgb;
      end else if (de_prev) begin
        video_rgb <= slot_word;
      end else begin
        video_rgb <= '0;
      end

      // hs fires as the count passes 1
      video_hs <= (hs_delay == HS_W'(1));

      if (!hs_prev && core_hs) begin
        // new rise restarts the window
        hs_delay <= HS_W'(`CORE_HS_DELAY);
      end else if (hs_delay != '0) begin
        hs_delay <= hs_delay - 1'b1;
      end

      // vs only on the sampled rise
      video_vs <= !vs_prev && core_vs;

      // edge history
      de_prev <= de;
      hs_prev <= core_hs;
      vs_prev <= core_vs;
    end
  end

  ////////////////////////////////////////
  // sync pulse checks
  ////////////////////////////////////////

  a_hs_single : assert property (
    @(posedge clk_74a) disable iff (!pll_core_locked)
    video_hs |=> !video_hs
  );

  a_vs_single : assert property (
    @(posedge clk_74a) disable iff (!pll_core_locked)
    video_vs |=> !video_vs
  );

endmodule

//--- hdl/core_top.sv
// clk_74a glue top level
// settings registers, data-slot tracker, video conditioner

`timescale 1ns/1ps

`include "core_config.svh"

module core_top
  import core_pkg::*;
#(
  parameter int unsigned RESET_HOLD = `CORE_RESET_HOLD
) (
  input  logic                         clk_74a,
  input  logic                         pll_core_locked,

  // bridge, writes only
  input  logic                         bridge_wr,
  input  logic [`CORE_ADDR_W-1:0]      bridge_addr,
  input  logic [`CORE_ADDR_W-1:0]      bridge_wr_data,

  // data slots
  input  logic                         dataslot_requestwrite,
  input  logic [15:0]                  dataslot_requestwrite_id,
  input  logic                         dataslot_allcomplete,
  input  logic                         has_save,
  output logic                         is_downloading,
  output logic                         ioctl_download,
  output logic                         palette_download,
  output logic [9:0]                   datatable_addr,
  output logic                         datatable_wren,
  output logic [31:0]                  datatable_data,

  // core video in
  input  logic                         core_hblank,
  input  logic                         core_vblank,
  input  logic                         core_hs,
  input  logic                         core_vs,
  input  logic [`CORE_RGB_W-1:0]       core_rgb,

  // scaler video out
  output logic                         video_de,
  output logic                         video_hs,
  output logic                         video_vs,
  output logic [`CORE_RGB_W-1:0]       video_rgb,

  // settings toward the core
  output region_e                      region,
  output logic [1:0]                   mask_vid_edges,
  output logic                         allow_extra_sprites,
  output logic [`CORE_PALETTE_W-1:0]   selected_palette,
  output logic                         multitap_enabled,
  output logic                         lightgun_enabled,
  output logic [`CORE_AIM_SPEED_W-1:0] lightgun_dpad_aim_speed,
  output logic                         swap_controllers,
  output logic [`CORE_TURBO_W-1:0]     turbo_speed,
  output logic                         external_reset
);

  // slot word flags, settings to video only
  logic hide_overscan_eff;
  logic square_pixels;

  settings_regs #(
    .RESET_HOLD (RESET_HOLD)
  ) u_settings_regs (
    .clk_74a                 (clk_74a),
    .pll_core_locked         (pll_core_locked),
    .bridge_wr               (bridge_wr),
    .bridge_addr             (bridge_addr),
    .bridge_wr_data          (bridge_wr_data),
    .region                  (region),
    .hide_overscan_eff       (hide_overscan_eff),
    .mask_vid_edges          (mask_vid_edges),
    .allow_extra_sprites     (allow_extra_sprites),
    .selected_palette        (selected_palette),
    .square_pixels           (square_pixels),
    .multitap_enabled        (multitap_enabled),
    .lightgun_enabled        (lightgun_enabled),
    .lightgun_dpad_aim_speed (lightgun_dpad_aim_speed),
    .swap_controllers        (swap_controllers),
    .turbo_speed             (turbo_speed),
    .external_reset          (external_reset)
  );

  dataslot_tracker u_dataslot_tracker (
    .clk_74a                  (clk_74a),
    .pll_core_locked          (pll_core_locked),
    .dataslot_requestwrite    (dataslot_requestwrite),
    .dataslot_requestwrite_id (dataslot_requestwrite_id),
    .dataslot_allcomplete     (dataslot_allcomplete),
    .has_save                 (has_save),
    .is_downloading           (is_downloading),
    .ioctl_download           (ioctl_download),
    .palette_download         (palette_download),
    .datatable_addr           (datatable_addr),
    .datatable_wren           (datatable_wren),
    .datatable_data           (datatable_data)
  );

  video_conditioner u_video_conditioner (
    .clk_74a           (clk_74a),
    .pll_core_locked   (pll_core_locked),
    .core_hblank       (core_hblank),
    .core_vblank       (core_vblank),
    .core_hs           (core_hs),
    .core_vs           (core_vs),
    .core_rgb          (core_rgb),
    .hide_overscan_eff (hide_overscan_eff),
    .square_pixels     (square_pixels),
    .video_de          (video_de),
    .video_hs          (video_hs),
    .video_vs          (video_vs),
    .video_rgb         (video_rgb)
  );

endmodule

//--- test/tb_core_top.sv
// testbench for the clk_74a glue top level
// seeded random bridge, data-slot and video stimulus
// cycle-level reference model with checks on the falling edge

`timescale 1ns/1ps

`include "core_config.svh"

module tb_core_top
  import core_pkg::*;
;

  localparam int HOLD = 64;
  localparam int RANDOM_CYCLES = 4000;

  logic clk_74a;
  logic pll_core_locked;
  logic bridge_wr;
  logic [31:0] bridge_addr;
  logic [31:0] bridge_wr_data;
  logic dataslot_requestwrite;
  logic [15:0] dataslot_requestwrite_id;
  logic dataslot_allcomplete;
  logic has_save;
  logic is_downloading;
  logic ioctl_download;
  logic palette_download;
  logic [9:0] datatable_addr;
  logic datatable_wren;
  logic [31:0] datatable_data;
  logic core_hblank;
  logic core_vblank;
  logic core_hs;
  logic core_vs;
  logic [`CORE_RGB_W-1:0] core_rgb;
  logic video_de;
  logic video_hs;
  logic video_vs;
  logic [`CORE_RGB_W-1:0] video_rgb;
  region_e region;
  logic [1:0] mask_vid_edges;
  logic allow_extra_sprites;
  logic [`CORE_PALETTE_W-1:0] selected_palette;
  logic multitap_enabled;
  logic lightgun_enabled;
  logic [`CORE_AIM_SPEED_W-1:0] lightgun_dpad_aim_speed;
  logic swap_controllers;
  logic [`CORE_TURBO_W-1:0] turbo_speed;
  logic external_reset;

  // reference model state
  int cyc;
  int reset_end;
  int region_chg_at;
  int hs_due;
  logic [1:0] exp_region;
  logic exp_hide;
  logic [1:0] exp_mask;
  logic exp_sprites;
  logic [2:0] exp_palette;
  logic exp_square;
  logic exp_multitap;
  logic exp_lightgun;
  logic [7:0] exp_aim;
  logic exp_swap;
  logic [2:0] exp_turbo;
  logic exp_active;
  logic [15:0] exp_slot;
  logic exp_wren;
  logic [31:0] exp_dt;
  logic exp_de;
  logic [23:0] exp_rgb;
  logic exp_hs;
  logic exp_vs;
  logic hs_last;
  logic vs_last;
  logic cur_de;

  int checks;
  int errors;
  int timeouts;

  // every mapped bridge offset
  logic [31:0] mapped [12] = '{32'h050, 32'h054, 32'h200, 32'h204, 32'h208, 32'h20C,
                               32'h210, 32'h300, 32'h304, 32'h308, 32'h30C, 32'h310};

  core_top #(
    .RESET_HOLD (HOLD)
  ) DUT (.*);

  initial begin
    clk_74a = 1'b0;
    forever #5 clk_74a = ~clk_74a;
  end

  ////////////////////////////////////////
  // helpers
  ////////////////////////////////////////

  function automatic logic [23:0] build_slot_word(input logic hide_eff, input logic square);
    logic [23:0] word;
    word = '0;
    word[`CORE_SLOT_HIDE_BIT] = hide_eff;
    word[`CORE_SLOT_SQUARE_BIT] = square;
    return word;
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    checks++;
    assert (actual === expected) else begin
      errors++;
      $display("[FAIL] %s expected %h actual %h at %0t", name, expected, actual, $time);
    end
  endtask

  // one-cycle write strobe
  task automatic bridge_write(input logic [31:0] addr, input logic [31:0] data);
    @(posedge clk_74a);
    bridge_wr      <= 1'b1;
    bridge_addr    <= addr;
    bridge_wr_data <= data;
    @(posedge clk_74a);
    bridge_wr      <= 1'b0;
  endtask

  // length of the next external_reset high run, in cycles
  task automatic measure_reset_run(output int len);
    int waited;
    len = 0;
    waited = 0;
    do begin
      @(negedge clk_74a);
      waited++;
    end while (!external_reset && waited < 16);
    if (!external_reset) begin
      timeouts++;
      $display("external_reset never rose after the write");
    end else begin
      while (external_reset && len < 10 * HOLD) begin
        len++;
        @(negedge clk_74a);
      end
      if (external_reset) begin
        timeouts++;
        $display("external_reset stuck high, timed out");
      end
    end
  endtask

  task automatic drive_random_cycle();
    @(posedge clk_74a);
    bridge_wr <= ($urandom_range(0, 3) == 0);
    // odd offsets are never mapped
    if ($urandom_range(0, 99) < 30) begin
      bridge_addr <= mapped[$urandom_range(0, 11)];
    end else begin
      bridge_addr <= $urandom() | 32'h1;
    end
    bridge_wr_data <= $urandom();
    dataslot_requestwrite <= ($urandom_range(0, 15) == 0);
    case ($urandom_range(0, 2))
      0: dataslot_requestwrite_id <= `CORE_SLOT_ROM_ID;
      1: dataslot_requestwrite_id <= `CORE_SLOT_PALETTE_ID;
      default: dataslot_requestwrite_id <= $urandom_range(1, 65535);
    endcase
    dataslot_allcomplete <= ($urandom_range(0, 11) == 0);
    has_save <= $urandom_range(0, 1);
    // blanking and sync flip now and then
    core_hblank <= core_hblank ^ ($urandom_range(0, 7) == 0);
    core_vblank <= core_vblank ^ ($urandom_range(0, 63) == 0);
    core_hs <= core_hs ^ ($urandom_range(0, 5) == 0);
    core_vs <= core_vs ^ ($urandom_range(0, 19) == 0);
    core_rgb <= $urandom();
  endtask

  ////////////////////////////////////////
  // reference model
  ////////////////////////////////////////

  always @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      cyc = 0;
      reset_end = 0;
      region_chg_at = -1;
      hs_due = -1;
      {exp_region, exp_hide, exp_mask, exp_sprites, exp_palette, exp_square} = '0;
      {exp_multitap, exp_lightgun, exp_aim, exp_swap, exp_turbo} = '0;
      {exp_active, exp_slot, exp_wren, exp_dt} = '0;
      {exp_de, exp_rgb, exp_hs, exp_vs, hs_last, vs_last} = '0;
    end else begin
      cyc = cyc + 1;
      // video uses the settings from before this edge
      cur_de = !(core_hblank || core_vblank);
      if (cur_de) begin
        exp_rgb = core_rgb;
      end else if (exp_de) begin
        exp_rgb = build_slot_word(exp_hide && (exp_region == 2'd0), exp_square);
      end else begin
        exp_rgb = '0;
      end
      exp_de = cur_de;
      exp_vs = core_vs && !vs_last;
      vs_last = core_vs;
      exp_hs = (cyc == hs_due);
      if (core_hs && !hs_last) begin
        hs_due = cyc + `CORE_HS_DELAY;
      end
      hs_last = core_hs;
      // data slots, request beats completion
      if (dataslot_requestwrite) begin
        exp_active = 1'b1;
        exp_slot = dataslot_requestwrite_id;
      end else if (dataslot_allcomplete) begin
        exp_active = 1'b0;
      end
      exp_wren = 1'b1;
      exp_dt = has_save ? `CORE_SAVE_SIZE : 32'h0;
      if (bridge_wr) begin
        case (bridge_addr)
          reg_reset: reset_end = cyc + HOLD;
          reg_region: begin
            if (bridge_wr_data[1:0] != exp_region) begin
              region_chg_at = cyc;
            end
            exp_region = bridge_wr_data[1:0];
          end
          reg_hide_overscan: exp_hide = bridge_wr_data[0];
          reg_mask_edges:    exp_mask = bridge_wr_data[1:0];
          reg_extra_sprites: exp_sprites = bridge_wr_data[0];
          reg_palette:       exp_palette = bridge_wr_data[2:0];
          reg_square_pixels: exp_square = bridge_wr_data[0];
          reg_multitap:      exp_multitap = bridge_wr_data[0];
          reg_lightgun:      exp_lightgun = bridge_wr_data[0];
          reg_aim_speed:     exp_aim = bridge_wr_data[7:0];
          reg_swap:          exp_swap = bridge_wr_data[0];
          reg_turbo:         exp_turbo = bridge_wr_data[2:0];
          default: ;
        endcase
      end
    end
  end

  // outputs settle well before the falling edge
  always @(negedge clk_74a) begin
    if (pll_core_locked) begin
      check_value("region", exp_region, region);
      check_value("hide_overscan_eff", exp_hide && (exp_region == 2'd0),
                  DUT.u_settings_regs.hide_overscan_eff);
      check_value("mask_vid_edges", exp_mask, mask_vid_edges);
      check_value("allow_extra_sprites", exp_sprites, allow_extra_sprites);
      check_value("selected_palette", exp_palette, selected_palette);
      check_value("multitap_enabled", exp_multitap, multitap_enabled);
      check_value("lightgun_enabled", exp_lightgun, lightgun_enabled);
      check_value("lightgun_dpad_aim_speed", exp_aim, lightgun_dpad_aim_speed);
      check_value("swap_controllers", exp_swap, swap_controllers);
      check_value("turbo_speed", exp_turbo, turbo_speed);
      check_value("external_reset", (cyc < reset_end) || (cyc == region_chg_at),
                  external_reset);
      check_value("is_downloading", exp_active, is_downloading);
      check_value("ioctl_download", exp_active && exp_slot == `CORE_SLOT_ROM_ID,
                  ioctl_download);
      check_value("palette_download", exp_active && exp_slot == `CORE_SLOT_PALETTE_ID,
                  palette_download);
      check_value("datatable_addr", `CORE_SAVE_TABLE_ADDR, datatable_addr);
      check_value("datatable_wren", exp_wren, datatable_wren);
      check_value("datatable_data", exp_dt, datatable_data);
      check_value("video_de", exp_de, video_de);
      check_value("video_rgb", exp_rgb, video_rgb);
      check_value("video_hs", exp_hs, video_hs);
      check_value("video_vs", exp_vs, video_vs);
    end
  end

  ////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////

  initial begin : stimulus
    int seed_ret;
    int run_len;
    seed_ret = $urandom(24);
    checks = 0;
    errors = 0;
    timeouts = 0;
    pll_core_locked = 1'b0;
    {bridge_wr, bridge_addr, bridge_wr_data} = '0;
    {dataslot_requestwrite, dataslot_requestwrite_id, dataslot_allcomplete, has_save} = '0;
    {core_hblank, core_vblank, core_hs, core_vs, core_rgb} = '0;
    repeat (5) @(posedge clk_74a);
    pll_core_locked <= 1'b1;

    // slot word flags on, then the hold
    bridge_write(reg_hide_overscan, 32'h1);
    bridge_write(reg_square_pixels, 32'hFFFF_FFFF);
    bridge_write(reg_reset, 32'h0);
    measure_reset_run(run_len);
    check_value("external_reset hold length", HOLD, run_len);

    // second write part way in restarts the count
    bridge_write(reg_reset, 32'h0);
    repeat (20) @(posedge clk_74a);
    bridge_write(reg_reset, 32'h0);
    measure_reset_run(run_len);
    check_value("external_reset restarted hold", HOLD, run_len);

    // region change gives a single-cycle reset
    bridge_write(reg_region, region_pal);
    measure_reset_run(run_len);
    check_value("external_reset region pulse", 1, run_len);
    bridge_write(reg_region, region_ntsc);
    measure_reset_run(run_len);
    check_value("external_reset region pulse", 1, run_len);

    repeat (RANDOM_CYCLES) drive_random_cycle();
    @(posedge clk_74a);
    bridge_wr <= 1'b0;
    dataslot_requestwrite <= 1'b0;
    dataslot_allcomplete <= 1'b0;
    repeat (HOLD + 10) @(posedge clk_74a);

    $display("checks %0d errors %0d timeouts %0d", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

  // whole-run limit
  initial begin : watchdog
    #1ms;
    $display("run did not finish in time");
    $display("SIMULATION FAILED");
    $finish;
  end

endmodule

//--- core_top.f
+incdir+hdl
hdl/core_pkg.sv
hdl/settings_regs.sv
hdl/dataslot_tracker.sv
hdl/video_conditioner.sv
hdl/core_top.sv
test/tb_core_top.sv
